//--- all.f
+incdir+include
src/exec_pkg.sv
src/int_alu.sv
src/branch_unit.sv
src/addr_gen.sv
src/int_divider.sv
src/operand_forward.sv
src/execute_stage.sv
tb/tb_execute.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_execute
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/exec_macros.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_execute.sv
`include "exec_macros.svh"

module tb_execute import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BUNDLES = 40 + 30 + 30 + 30 + 15 + 40;
  localparam int LIMIT   = BUNDLES * (`DIV_STEPS + 2) + BUNDLES * 4 + 500;

  logic         clock = 1'b0;
  logic         reset;
  logic         issue_valid;
  logic         issue_ready;
  exec_issue_t  issue;
  logic         result_valid;
  logic         result_ready;
  exec_result_t result;

  logic [31:0]      lfsr = 32'h348f_9d27;
  logic [`XLEN-1:0] regs [32];
  logic [`XLEN-1:0] arch [32];
  exec_result_t     exp_q [$];
  exec_result_t     expected;
  string            test_name = "reset";
  logic             bp_on = 1'b0;
  logic             ready_next;
  int               errors = 0;
  int               bundles = 0;
  int               transfers = 0;
  int               tests = 0;
  int               cycles = 0;
  int               div_wait;

  execute_stage i_execute_stage (
    .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue_ready(issue_ready),
    .issue(issue), .result_valid(result_valid), .result_ready(result_ready),
    .result(result)
  );

  always #10 clock = !clock;

  // Galois LFSR, one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        lsb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h8020_0003;
      value = {value[30:0], lsb};
    end
    return value;
  endfunction

  function automatic logic [`XLEN-1:0] alu_model(alu_op_t op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_sll:  return a << b[4:0];
      alu_srl:  return a >> b[4:0];
      alu_sra:  return $signed(a) >>> b[4:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
      default:  return (a < b) ? 1 : 0;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] div_model(div_op_t op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    logic overflow;
    logic quotient;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    quotient = (op == div_div) || (op == div_divu);
    if (b == 0) return quotient ? '1 : a;
    if (overflow && op == div_div) return a;
    if (overflow && op == div_rem) return '0;
    case (op)
      div_div:  return $signed(a) / $signed(b);
      div_divu: return a / b;
      div_rem:  return $signed(a) % $signed(b);
      default:  return a % b;
    endcase
  endfunction

  function automatic exec_result_t model(exec_slot_t s0, exec_slot_t s1);
    exec_result_t     r;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic             take;
    a = arch[s0.rs1];
    b = arch[s0.rs2];
    r = '0;
    r.address = (s0.op_class == op_auipc) ? s0.pc + s0.imm : a + s0.imm;
    case (s0.branch_op)
      br_beq:  take = a == b;
      br_bne:  take = a != b;
      br_blt:  take = $signed(a) < $signed(b);
      br_bge:  take = $signed(a) >= $signed(b);
      br_bltu: take = a < b;
      default: take = a >= b;
    endcase
    case (s0.op_class)
      op_lui:          r.lane0.wdata = s0.imm;
      op_auipc:        r.lane0.wdata = r.address;
      op_jal, op_jalr: r.lane0.wdata = s0.pc + 4;
      op_div:          r.lane0.wdata = div_model(s0.div_op, a, b);
      default:         r.lane0.wdata = alu_model(s0.alu_op, a, s0.use_imm ? s0.imm : b);
    endcase
    r.exception  = (s0.op_class inside {op_load, op_store}) && r.address[1:0] != 0;
    r.mem_load   = s0.op_class == op_load && !r.exception;
    r.mem_store  = s0.op_class == op_store && !r.exception;
    r.byteenable = '1;
    r.sdata      = b;
    r.redirect   = s0.op_class inside {op_jal, op_jalr} || (s0.op_class == op_branch && take);
    r.target     = (s0.op_class == op_jalr) ? (a + s0.imm) & ~32'd1 : s0.pc + s0.imm;
    r.lane0.valid = 1'b1;
    r.lane0.rd    = s0.rd;
    r.lane0.wren  = s0.rd != 0 && !(s0.op_class inside {op_branch, op_store}) && !r.exception;
    r.lane1.valid = !(r.redirect || r.exception);
    r.lane1.rd    = s1.rd;
    r.lane1.wren  = r.lane1.valid && s1.rd != 0;
    r.lane1.wdata = alu_model(s1.alu_op, arch[s1.rs1], s1.use_imm ? s1.imm : arch[s1.rs2]);
    return r;
  endfunction

  // Fields that the rules leave open are not compared.
  function automatic logic result_ok(exec_result_t e, exec_result_t a);
    logic ok;
    ok = e.lane0.valid == a.lane0.valid && e.lane0.wren == a.lane0.wren &&
         e.lane1.valid == a.lane1.valid && e.lane1.wren == a.lane1.wren &&
         e.mem_load == a.mem_load && e.mem_store == a.mem_store &&
         e.exception == a.exception && e.redirect == a.redirect;
    if (e.lane0.wren) ok = ok && e.lane0.rd == a.lane0.rd && e.lane0.wdata == a.lane0.wdata;
    if (e.lane1.wren) ok = ok && e.lane1.rd == a.lane1.rd && e.lane1.wdata == a.lane1.wdata;
    if (e.mem_load || e.mem_store) begin
      ok = ok && e.address == a.address && e.byteenable == a.byteenable &&
           e.sdata == a.sdata;
    end
    if (e.redirect) ok = ok && e.target == a.target;
    return ok;
  endfunction

  function automatic exec_slot_t make_slot(op_class_t cls, logic [4:0] mask);
    exec_slot_t s;
    s           = '0;
    s.valid     = 1'b1;
    s.op_class  = cls;
    s.use_imm   = 1'(rand_bits(1));
    s.alu_op    = alu_op_t'(rand_bits(4) % 10);
    s.branch_op = branch_op_t'(rand_bits(3) % 6);
    s.div_op    = div_op_t'(rand_bits(2));
    s.rs1       = 5'(rand_bits(5) & mask);
    s.rs2       = 5'(rand_bits(5) & mask);
    s.rd        = 5'(rand_bits(5) & mask);
    s.imm       = rand_bits(32);
    s.pc        = rand_bits(30) << 2;
    if (cls inside {op_load, op_store}) begin
      s.alu_op  = alu_add;
      s.use_imm = 1'b1;
    end
    return s;
  endfunction

  task automatic run_bundle(exec_slot_t s0, exec_slot_t s1);
    exec_result_t e;
    logic         accepted;
    // Lane 1 never reads lane 0's destination.
    if (s0.rd != 0 && s1.rs1 == s0.rd) s1.rs1 = s0.rd ^ 5'd1;
    if (s0.rd != 0 && s1.rs2 == s0.rd) s1.rs2 = s0.rd ^ 5'd1;
    e = model(s0, s1);
    if (e.lane0.wren) arch[e.lane0.rd] = e.lane0.wdata;
    if (e.lane1.wren) arch[e.lane1.rd] = e.lane1.wdata;
    exp_q.push_back(e);
    bundles++;
    accepted    = 1'b0;
    issue_valid = 1'b1;
    while (!accepted) begin
      issue.slot0        = s0;
      issue.slot0.rdata1 = regs[s0.rs1];
      issue.slot0.rdata2 = regs[s0.rs2];
      issue.slot1        = s1;
      issue.slot1.rdata1 = regs[s1.rs1];
      issue.slot1.rdata2 = regs[s1.rs2];
      @(negedge clock);
      accepted = issue_ready;
      @(posedge clock);
      #2;
    end
    issue_valid = 1'b0;
  endtask

  task automatic run_test(string name, int count, int kind);
    exec_slot_t s0;
    exec_slot_t s1;
    int         errs_before;
    test_name   = name;
    errs_before = errors;
    for (int i = 0; i < count; i++) begin
      s1 = make_slot(op_alu, (kind == 2) ? 5'h03 : 5'h1f);
      case (kind)
        1: s0 = make_slot(op_class_t'(rand_bits(2) % 3), 5'h1f);
        2: s0 = make_slot(op_alu, 5'h03);
        3: s0 = make_slot(op_class_t'(op_branch + rand_bits(2) % 3), 5'h03);
        4: s0 = make_slot(rand_bits(1) ? op_load : op_store, 5'h1f);
        5: s0 = make_slot(op_div, 5'h1f);
        default: s0 = make_slot(op_class_t'(rand_bits(4) % 9), 5'h07);
      endcase
      if (kind == 5 && i < 5) begin
        // Most negative number in x5 and minus one in x6, then corner divides.
        s0.rs1 = 5;
        s0.rs2 = (i < 3) ? 5'd6 : 5'd0;
        s0.rd  = 7;
        s0.div_op = (i == 1) ? div_div : (i == 2) ? div_rem : (i == 3) ? div_divu : div_remu;
        // Lane 1 keeps clear of the corner operands.
        if (s1.rd == 5'd5 || s1.rd == 5'd6) s1.rd = 5'd8;
        if (i == 0) begin
          s0 = make_slot(op_lui, 5'h00);
          s0.rd  = 5;
          s0.imm = 32'h8000_0000;
          s1.alu_op  = alu_add;
          s1.use_imm = 1'b1;
          s1.rs1 = 0;
          s1.rd  = 6;
          s1.imm = '1;
        end
      end
      run_bundle(s0, s1);
    end
    while (exp_q.size() != 0) begin
      @(posedge clock);
      #2;
    end
    tests++;
    $display("%s: %0d bundles, %0d errors", name, count, errors - errs_before);
  endtask

  always @(posedge clock) begin
    ready_next = bp_on ? (rand_bits(2) != 0) : 1'b1;
    #2;
    result_ready = ready_next;
  end

  // Transfers commit to the register file model.
  always @(posedge clock) begin
    if (reset && result_valid && result_ready) begin
      transfers++;
      if (exp_q.size() == 0) begin
        $display("A result was handed off with no bundle outstanding in %s", test_name);
        errors++;
      end else begin
        if (exp_q[0].lane0.wren) regs[exp_q[0].lane0.rd] = exp_q[0].lane0.wdata;
        if (exp_q[0].lane1.wren) regs[exp_q[0].lane1.rd] = exp_q[0].lane1.wdata;
        void'(exp_q.pop_front());
      end
    end
    if (exp_q.size() != 0) expected <= exp_q[0];
  end

  always @(posedge clock) begin
    if (!reset) begin
      div_wait <= 0;
    end else if (issue_valid && issue_ready && issue.slot0.op_class == op_div) begin
      div_wait <= `DIV_STEPS;
    end else if (div_wait != 0) begin
      div_wait <= div_wait - 1;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles in %s", cycles, test_name);
      $display("TESTS FAILED");
      $finish;
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    result_valid && result_ready |-> result_ok(expected, result))
    else begin
      $display("** Error %s: expected %h, actual %h", test_name,
               $sampled(expected), $sampled(result));
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else begin
      $display("Result changed or vanished before it was accepted in %s", test_name);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) div_wait != 0 |-> !issue_ready)
    else begin
      $display("Issue was ready while the divider was still working in %s", test_name);
      errors++;
    end

  initial begin
    reset        = 1'b0;
    issue_valid  = 1'b0;
    issue        = '0;
    result_ready = 1'b1;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
      arch[i] = '0;
    end
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b1;
    run_test("alu", 40, 1);
    run_test("forward", 30, 2);
    run_test("branch", 30, 3);
    run_test("memory", 30, 4);
    run_test("divide", 15, 5);
    bp_on = 1'b1;
    run_test("backpressure", 40, 6);
    if (transfers != bundles) begin
      $display("Transfer count %0d does not match bundle count %0d", transfers, bundles);
      errors++;
    end
    $display("%0d tests, %0d bundles, %0d transfers, %0d errors",
             tests, bundles, transfers, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src/execute_stage.sv
`include "exec_macros.svh"

module execute_stage import exec_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         issue_valid,
  output logic         issue_ready,
  input  exec_issue_t  issue,
  output logic         result_valid,
  input  logic         result_ready,
  output exec_result_t result
);

  exec_slot_t         slot0_fwd;
  exec_slot_t         slot1_fwd;
  logic [`XLEN-1:0]   fwd0_rdata1;
  logic [`XLEN-1:0]   fwd0_rdata2;
  logic [`XLEN-1:0]   fwd1_rdata1;
  logic [`XLEN-1:0]   fwd1_rdata2;
  logic [`XLEN-1:0]   alu0_result;
  logic [`XLEN-1:0]   alu1_result;
  logic               taken;
  logic [`XLEN-1:0]   address;
  logic [`XLEN/8-1:0] byteenable;
  logic [`XLEN-1:0]   target;
  logic               misaligned;
  logic               div_start;
  logic               div_busy;
  logic               div_done;
  logic [`XLEN-1:0]   div_result;
  logic               div_pending;
  logic               issue_fire;
  logic               is_div;
  logic               writes_rd;
  exec_result_t       next_result;
  exec_result_t       staged;

  operand_forward i_fwd0 (
    .slot(issue.slot0), .prev(result), .prev_valid(result_valid),
    .rdata1(fwd0_rdata1), .rdata2(fwd0_rdata2)
  );

  operand_forward i_fwd1 (
    .slot(issue.slot1), .prev(result), .prev_valid(result_valid),
    .rdata1(fwd1_rdata1), .rdata2(fwd1_rdata2)
  );

  always_comb begin
    slot0_fwd        = issue.slot0;
    slot0_fwd.rdata1 = fwd0_rdata1;
    slot0_fwd.rdata2 = fwd0_rdata2;
    slot1_fwd        = issue.slot1;
    slot1_fwd.rdata1 = fwd1_rdata1;
    slot1_fwd.rdata2 = fwd1_rdata2;
  end

  int_alu i_alu0 (.in(slot0_fwd), .result(alu0_result));
  int_alu i_alu1 (.in(slot1_fwd), .result(alu1_result));

  branch_unit i_branch (
    .rdata1(slot0_fwd.rdata1), .rdata2(slot0_fwd.rdata2),
    .branch_op(slot0_fwd.branch_op), .taken(taken)
  );

  addr_gen i_agu (
    .in(slot0_fwd), .address(address), .byteenable(byteenable),
    .target(target), .misaligned(misaligned)
  );

  assign issue_fire = issue_valid && issue_ready;
  assign is_div     = issue.slot0.valid && issue.slot0.op_class == op_div;
  assign div_start  = issue_fire && is_div;

  int_divider i_div (
    .clock(clock), .reset(reset), .start(div_start), .div_op(slot0_fwd.div_op),
    .dividend(slot0_fwd.rdata1), .divisor(slot0_fwd.rdata2),
    .busy(div_busy), .done(div_done), .result(div_result), .ack(div_done)
  );

  // Pending covers the whole divide, including the cycle done is seen.
  assign issue_ready = !div_pending && (!result_valid || result_ready);

  assign writes_rd = !(slot0_fwd.op_class inside {op_branch, op_store});

  always_comb begin
    next_result = '0;
    case (slot0_fwd.op_class)
      op_auipc:        next_result.lane0.wdata = address;
      op_lui:          next_result.lane0.wdata = slot0_fwd.imm;
      op_jal, op_jalr: next_result.lane0.wdata = slot0_fwd.pc + `XLEN'd4;
      default:         next_result.lane0.wdata = alu0_result;
    endcase
    next_result.lane0.valid = slot0_fwd.valid;
    next_result.lane0.rd    = slot0_fwd.rd;
    next_result.lane0.wren  = slot0_fwd.valid && writes_rd && slot0_fwd.rd != '0 && !misaligned;

    next_result.exception  = slot0_fwd.valid && misaligned;
    next_result.mem_load   = slot0_fwd.valid && slot0_fwd.op_class == op_load && !misaligned;
    next_result.mem_store  = slot0_fwd.valid && slot0_fwd.op_class == op_store && !misaligned;
    next_result.address    = address;
    next_result.byteenable = byteenable;
    next_result.sdata      = slot0_fwd.rdata2;
    next_result.redirect   = slot0_fwd.valid &&
                             (slot0_fwd.op_class inside {op_jal, op_jalr} ||
                              (slot0_fwd.op_class == op_branch && taken));
    next_result.target     = target;

    // Lane 1 is younger than a redirect or a faulting access.
    next_result.lane1.valid = slot1_fwd.valid && !next_result.redirect &&
                              !next_result.exception;
    next_result.lane1.rd    = slot1_fwd.rd;
    next_result.lane1.wren  = next_result.lane1.valid && slot1_fwd.rd != '0;
    next_result.lane1.wdata = alu1_result;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      result_valid <= 1'b0;
      div_pending  <= 1'b0;
    end else if (issue_fire) begin
      result_valid <= !is_div;
      div_pending  <= is_div;
    end else if (div_done) begin
      result_valid <= 1'b1;
      div_pending  <= 1'b0;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_fire && is_div) begin
      staged <= next_result;
    end
    if (issue_fire && !is_div) begin
      result <= next_result;
    end else if (div_done) begin
      result             <= staged;
      result.lane0.wdata <= div_result;
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else $error("result changed under back-pressure");

  assert property (@(posedge clock) disable iff (!reset) div_busy |-> !issue_ready)
    else $error("issue accepted while divider busy");

endmodule

//--- src/operand_forward.sv
`include "exec_macros.svh"

module operand_forward import exec_pkg::*; (
  input  exec_slot_t       slot,
  input  exec_result_t     prev,
  input  logic             prev_valid,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2
);

  function automatic logic [`XLEN-1:0] pick(input logic [`REG_ADDR_W-1:0] addr,
                                            input logic [`XLEN-1:0] regval);
    logic [`XLEN-1:0] value;
    value = regval;
    if (prev_valid && addr != '0) begin
      if (prev.lane0.wren && prev.lane0.rd == addr) value = prev.lane0.wdata;
      // Lane 1 is younger.
      if (prev.lane1.wren && prev.lane1.rd == addr) value = prev.lane1.wdata;
    end
    return value;
  endfunction

  always_comb begin
    rdata1 = pick(slot.rs1, slot.rdata1);
    rdata2 = pick(slot.rs2, slot.rdata2);
  end

endmodule

//--- src/int_divider.sv
`include "exec_macros.svh"

module int_divider import exec_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  div_op_t          div_op,
  input  logic [`XLEN-1:0] dividend,
  input  logic [`XLEN-1:0] divisor,
  output logic             busy,
  output logic             done,
  output logic [`XLEN-1:0] result,
  input  logic             ack
);

  localparam int CNT_W = $clog2(`DIV_STEPS);

  div_state_t       state;
  logic [CNT_W-1:0] count;
  div_op_t          op_q;
  logic [`XLEN-1:0] dividend_q;
  logic [`XLEN-1:0] divisor_q;
  logic [`XLEN-1:0] dmag_q;
  logic [`XLEN-1:0] quo_q;
  logic [`XLEN-1:0] rem_q;
  logic             neg_q;
  logic             neg_r;
  logic             is_signed;
  logic             a_neg;
  logic             b_neg;
  logic [`XLEN:0]   shifted;
  logic [`XLEN:0]   diff;
  logic [`XLEN-1:0] quo_fix;
  logic [`XLEN-1:0] rem_fix;

  assign is_signed = (div_op == div_div) || (div_op == div_rem);
  assign a_neg     = is_signed && dividend[`XLEN-1];
  assign b_neg     = is_signed && divisor[`XLEN-1];
  assign shifted   = {rem_q, quo_q[`XLEN-1]};
  assign diff      = shifted - {1'b0, dmag_q};

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= ds_idle;
    end else begin
      case (state)
        ds_idle: if (start) state <= ds_busy;
        ds_busy: if (count == CNT_W'(`DIV_STEPS - 1)) state <= ds_done;
        ds_done: if (ack) state <= ds_idle;
        default: state <= ds_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == ds_idle && start) begin
      op_q       <= div_op;
      dividend_q <= dividend;
      divisor_q  <= divisor;
      dmag_q     <= b_neg ? -divisor : divisor;
      quo_q      <= a_neg ? -dividend : dividend;
      rem_q      <= '0;
      neg_q      <= a_neg ^ b_neg;
      neg_r      <= a_neg;
      count      <= '0;
    end else if (state == ds_busy) begin
      // Restoring step, keep the partial remainder only if it stays positive.
      if (!diff[`XLEN]) begin
        rem_q <= diff[`XLEN-1:0];
        quo_q <= {quo_q[`XLEN-2:0], 1'b1};
      end else begin
        rem_q <= shifted[`XLEN-1:0];
        quo_q <= {quo_q[`XLEN-2:0], 1'b0};
      end
      count <= count + 1'b1;
    end
  end

  assign quo_fix = neg_q ? -quo_q : quo_q;
  assign rem_fix = neg_r ? -rem_q : rem_q;

  always_comb begin
    if (divisor_q == '0) begin
      result = (op_q == div_div || op_q == div_divu) ? '1 : dividend_q;
    end else if ((op_q == div_div || op_q == div_rem) && divisor_q == '1 &&
                 dividend_q == {1'b1, {(`XLEN-1){1'b0}}}) begin
      // Signed overflow.
      result = (op_q == div_div) ? dividend_q : '0;
    end else begin
      result = (op_q == div_div || op_q == div_divu) ? quo_fix : rem_fix;
    end
  end

  assign busy = state == ds_busy;
  assign done = state == ds_done;

  assert property (@(posedge clock) disable iff (!reset) start |-> !busy && !done)
    else $error("divider started while still working");
  assert property (@(posedge clock) disable iff (!reset) ack |-> done)
    else $error("divider ack without done");

endmodule

//--- src/addr_gen.sv
`include "exec_macros.svh"

module addr_gen import exec_pkg::*; (
  input  exec_slot_t         in,
  output logic [`XLEN-1:0]   address,
  output logic [`XLEN/8-1:0] byteenable,
  output logic [`XLEN-1:0]   target,
  output logic               misaligned
);

  logic [`XLEN-1:0] reg_sum;
  logic [`XLEN-1:0] pc_sum;
  logic             is_mem;

  assign reg_sum = in.rdata1 + in.imm;
  assign pc_sum  = in.pc + in.imm;
  assign is_mem  = (in.op_class == op_load) || (in.op_class == op_store);

  // auipc shares the pc adder; every other class uses the register base.
  assign address = (in.op_class == op_auipc) ? pc_sum : reg_sum;

  always_comb begin
    if (in.op_class == op_jalr) begin
      target = {reg_sum[`XLEN-1:1], 1'b0};
    end else begin
      target = pc_sum;
    end
  end

  // Word accesses only.
  assign byteenable = '1;
  assign misaligned = is_mem && (address[1:0] != 2'b00);

endmodule

//--- src/branch_unit.sv
`include "exec_macros.svh"

module branch_unit import exec_pkg::*; (
  input  logic [`XLEN-1:0] rdata1,
  input  logic [`XLEN-1:0] rdata2,
  input  branch_op_t       branch_op,
  output logic             taken
);

  logic equal;
  logic less_signed;
  logic less_unsigned;

  assign equal         = rdata1 == rdata2;
  assign less_signed   = $signed(rdata1) < $signed(rdata2);
  assign less_unsigned = rdata1 < rdata2;

  always_comb begin
    case (branch_op)
      br_beq:  taken = equal;
      br_bne:  taken = !equal;
      br_blt:  taken = less_signed;
      br_bge:  taken = !less_signed;
      br_bltu: taken = less_unsigned;
      br_bgeu: taken = !less_unsigned;
      default: taken = 1'b0;
    endcase
  end

endmodule

//--- src/int_alu.sv
`include "exec_macros.svh"

module int_alu import exec_pkg::*; (
  input  exec_slot_t       in,
  output logic [`XLEN-1:0] result
);

  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;

  assign a = in.rdata1;
  assign b = in.use_imm ? in.imm : in.rdata2;

  always_comb begin
    case (in.alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      // Shift amount is the low five bits only.
      alu_sll:  result = a << b[4:0];
      alu_srl:  result = a >> b[4:0];
      alu_sra:  result = $unsigned($signed(a) >>> b[4:0]);
      alu_slt:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu: result = {{(`XLEN-1){1'b0}}, a < b};
      default:  result = '0;
    endcase
  end

endmodule

//--- src/exec_pkg.sv
`include "exec_macros.svh"

package exec_pkg;

  typedef enum logic [3:0] {
    op_alu, op_lui, op_auipc, op_branch, op_jal,
    op_jalr, op_load, op_store, op_div
  } op_class_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_t;

  typedef enum logic [2:0] {
    br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } branch_op_t;

  typedef enum logic [1:0] {
    div_div, div_divu, div_rem, div_remu
  } div_op_t;

  typedef enum logic [1:0] {
    ds_idle, ds_busy, ds_done
  } div_state_t;

  // One issued instruction with its register file values.
  typedef struct packed {
    logic                   valid;
    op_class_t              op_class;
    logic                   use_imm;
    alu_op_t                alu_op;
    branch_op_t             branch_op;
    div_op_t                div_op;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rdata1;
    logic [`XLEN-1:0]       rdata2;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       pc;
  } exec_slot_t;

  typedef struct packed {
    exec_slot_t slot0;
    exec_slot_t slot1;
  } exec_issue_t;

  typedef struct packed {
    logic                   valid;
    logic                   wren;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       wdata;
  } exec_lane_result_t;

  typedef struct packed {
    exec_lane_result_t  lane0;
    exec_lane_result_t  lane1;
    logic               mem_load;
    logic               mem_store;
    logic [`XLEN-1:0]   address;
    logic [`XLEN/8-1:0] byteenable;
    logic [`XLEN-1:0]   sdata;
    logic               exception;
    logic               redirect;
    logic [`XLEN-1:0]   target;
  } exec_result_t;

endpackage

//--- include/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data path width of the RV32 integer core.
`define XLEN 32

`define REG_ADDR_W 5

// One restoring step per quotient bit.
`define DIV_STEPS 32

`endif
